// File: coproc_pkg.sv
/*
 * Shared definitions for the modular arithmetic coprocessor
 * Word and command types and the opcode encoding
 * Prime modulus and the folding constant used by the reducer
 * Operand RAM and command ROM sizes, hardware loop bounds
 */
package coproc_pkg;

    localparam int RAM_ADDR_W = 6;
    localparam int RAM_DEPTH  = 64;
    localparam int PC_W       = 5;
    localparam int ROM_DEPTH  = 32;
    localparam int TIMES_W    = 9;

    typedef logic [15:0] word_t;

    typedef enum logic [1:0] {
        OP_ADD   = 2'd0,
        OP_SUB   = 2'd1,
        OP_CUBIC = 2'd2,
        OP_MULT  = 2'd3
    } op_t;

    // Command word as stored in the ROM, 29 bits from dest down to src2
    typedef struct packed {
        logic [RAM_ADDR_W-1:0] dest;
        logic [RAM_ADDR_W-1:0] src1;
        op_t                   op;
        logic [TIMES_W-1:0]    times;
        logic [RAM_ADDR_W-1:0] src2;
    } cmd_t;

    localparam word_t MODULUS = 16'd65521;

    // Value of 2^16 modulo MODULUS, lets the upper product half fold back in
    localparam word_t FOLD = 16'(17'h1_0000 - 17'(MODULUS));

    localparam logic [PC_W-1:0] LOOP_START = 5'd4;
    localparam logic [PC_W-1:0] LOOP_END   = 5'd7;
    localparam logic [3:0]      LOOP_COUNT = 4'd3;

endpackage

// File: coproc_ifs.sv
/*
 * Internal connections of the coprocessor
 * ram_port_if carries the two read ports and the write port of the operand RAM
 * pe_ctrl_if carries the controls and the result of the processing element
 */
`timescale 1ns/1ps

interface ram_port_if import coproc_pkg::*; ();
    logic [RAM_ADDR_W-1:0] a_addr;
    logic [RAM_ADDR_W-1:0] b_addr;
    word_t                 a_data;
    word_t                 b_data;
    logic                  w_en;
    logic [RAM_ADDR_W-1:0] w_addr;
    word_t                 w_data;

    modport ctrl (output a_addr, b_addr, w_en, w_addr);
    modport mem  (input a_addr, b_addr, w_en, w_addr, w_data, output a_data, b_data);
endinterface

interface pe_ctrl_if import coproc_pkg::*; ();
    logic  load;
    logic  step;
    op_t   op;
    word_t result;

    modport ctrl (output load, step, op);
    modport pe   (input load, step, op, output result);
endinterface

// File: program_rom.sv
/*
 * Command ROM of the coprocessor
 * Contents come from program.hex, the read is combinational
 */
`timescale 1ns/1ps

module program_rom import coproc_pkg::*; (
    input  logic [PC_W-1:0] pc,
    output cmd_t            cmd
);

    cmd_t rom [ROM_DEPTH];

    // Words not listed in the file stay zero, which decodes as a halt
    initial
    begin
        for (int i = 0; i < ROM_DEPTH; i++)
        begin
            rom[i] = '0;
        end
        $readmemh("program.hex", rom);
    end

    assign cmd = rom[pc];

endmodule

// File: operand_ram.sv
/*
 * Operand RAM with 64 words of 16 bits
 * Two registered read ports and one write port
 * Initial contents from ram_init.hex, other words start at zero
 */
`timescale 1ns/1ps

module operand_ram import coproc_pkg::*; (
    input  logic      clk,
    ram_port_if.mem   port
);

    word_t mem [RAM_DEPTH];

    initial
    begin
        for (int i = 0; i < RAM_DEPTH; i++)
        begin
            mem[i] = '0;
        end
        $readmemh("ram_init.hex", mem);
    end

    // Reads sample the array before the write lands, so a colliding read
    // returns the old word
    always_ff @(posedge clk)
    begin
        port.a_data <= mem[port.a_addr];
        port.b_data <= mem[port.b_addr];
        if (port.w_en)
        begin
            mem[port.w_addr] <= port.w_data;
        end
    end

endmodule

// File: microcode_fsm.sv
/*
 * Command sequencer of the coprocessor
 * FSM over START, READ, LOAD, CALC, WAIT, WRITE and HALT
 * Program counter with one hardware loop, step counter and done flag
 */
`timescale 1ns/1ps

module microcode_fsm import coproc_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    output logic [PC_W-1:0] pc,
    input  cmd_t            cmd,
    ram_port_if.ctrl        ram,
    pe_ctrl_if.ctrl         pe,
    output logic            done
);

    typedef enum logic [2:0] {
        S_START,
        S_READ,
        S_LOAD,
        S_CALC,
        S_WAIT,
        S_WRITE,
        S_HALT
    } state_t;

    state_t                        state;
    state_t                        state_next;
    cmd_t                          cmd_q;
    logic [TIMES_W-1:0]            step_cnt;
    logic [$bits(LOOP_COUNT)-1:0]  loop_cnt;

    always_comb
    begin
        state_next = state;
        case (state)
            S_START: state_next = S_READ;
            S_READ:  state_next = S_LOAD;
            S_LOAD:  state_next = (cmd_q.times == '0) ? S_HALT : S_CALC;
            S_CALC:  state_next = (step_cnt == TIMES_W'(1)) ? S_WAIT : S_CALC;
            S_WAIT:  state_next = S_WRITE;
            S_WRITE: state_next = S_READ;
            default: state_next = S_HALT;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= S_START;
        else
            state <= state_next;
    end

    // The pc moves on in WAIT, so the fields still needed in WRITE are kept here
    always_ff @(posedge clk)
    begin
        if (state == S_READ)
            cmd_q <= cmd;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            step_cnt <= '0;
        else if (state == S_READ)
            step_cnt <= cmd.times;
        else if (state == S_CALC)
            step_cnt <= step_cnt - 1'b1;
    end

    // Jump back from the end of the loop body until the last pass has run
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc       <= '0;
            loop_cnt <= LOOP_COUNT;
        end
        else if (state == S_WAIT)
        begin
            if (pc == LOOP_END && loop_cnt > 1)
            begin
                pc       <= LOOP_START;
                loop_cnt <= loop_cnt - 1'b1;
            end
            else
            begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Goes high one cycle after HALT is entered and holds there
    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else if (state == S_HALT)
            done <= 1'b1;
    end

    // Addresses follow the ROM output, they are sampled by the RAM in READ
    assign ram.a_addr = cmd.src1;
    assign ram.b_addr = cmd.src2;
    assign ram.w_en   = (state == S_WRITE);
    assign ram.w_addr = cmd_q.dest;

    assign pe.load = (state == S_LOAD);
    assign pe.step = (state == S_CALC);
    assign pe.op   = cmd_q.op;

endmodule

// File: modular_pe.sv
/*
 * Accumulator processing element for arithmetic modulo 65521
 * Load takes both operands, each step applies ADD, SUB, CUBIC or MULT
 * Products are reduced by folding the upper half back in
 */
`timescale 1ns/1ps

module modular_pe import coproc_pkg::*; (
    input  logic  clk,
    pe_ctrl_if.pe pe,
    input  word_t a_data,
    input  word_t b_data
);

    word_t       acc;
    word_t       opnd;
    word_t       acc_next;
    word_t       square;
    logic [16:0] sum;
    logic [16:0] diff;

    // Brings a raw RAM word into the range 0 to MODULUS-1
    function automatic word_t canon(input word_t x);
        canon = (x >= MODULUS) ? x - MODULUS : x;
    endfunction

    function automatic word_t mod_mul(input word_t x, input word_t y);
        logic [31:0] prod;
        logic [19:0] fold1;
        logic [16:0] fold2;
        prod  = 32'(x) * 32'(y);
        // Two folds leave at most MODULUS plus a small remainder
        fold1 = 20'(prod[31:16]) * 20'(FOLD) + 20'(prod[15:0]);
        fold2 = 17'(fold1[19:16]) * 17'(FOLD) + 17'(fold1[15:0]);
        mod_mul = (fold2 >= 17'(MODULUS)) ? 16'(fold2 - 17'(MODULUS)) : fold2[15:0];
    endfunction

    always_comb
    begin
        sum    = {1'b0, acc} + {1'b0, opnd};
        diff   = {1'b0, acc} + ((acc < opnd) ? 17'(MODULUS) : 17'd0) - {1'b0, opnd};
        square = mod_mul(acc, acc);
        case (pe.op)
            OP_ADD:   acc_next = (sum >= 17'(MODULUS)) ? 16'(sum - 17'(MODULUS)) : sum[15:0];
            OP_SUB:   acc_next = diff[15:0];
            OP_CUBIC: acc_next = mod_mul(square, acc);
            OP_MULT:  acc_next = mod_mul(acc, opnd);
            default:  acc_next = acc;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (pe.load)
        begin
            acc  <= canon(a_data);
            opnd <= canon(b_data);
        end
        else if (pe.step)
        begin
            acc <= acc_next;
        end
    end

    assign pe.result = acc;

endmodule

// File: coproc_top.sv
/*
 * Top level of the modular arithmetic coprocessor
 * Connects command ROM, sequencer, operand RAM and processing element
 * The RAM write port is visible at the top for observation
 */
`timescale 1ns/1ps

module coproc_top import coproc_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  done,
    output logic [PC_W-1:0]       pc,
    output logic                  wr_en,
    output logic [RAM_ADDR_W-1:0] wr_addr,
    output word_t                 wr_data
);

    cmd_t cmd;

    ram_port_if ram_if ();
    pe_ctrl_if  pe_if ();

    program_rom i_program_rom (
        .pc  (pc),
        .cmd (cmd)
    );

    microcode_fsm i_microcode_fsm (
        .clk   (clk),
        .reset (reset),
        .pc    (pc),
        .cmd   (cmd),
        .ram   (ram_if.ctrl),
        .pe    (pe_if.ctrl),
        .done  (done)
    );

    operand_ram i_operand_ram (
        .clk  (clk),
        .port (ram_if.mem)
    );

    modular_pe i_modular_pe (
        .clk    (clk),
        .pe     (pe_if.pe),
        .a_data (ram_if.a_data),
        .b_data (ram_if.b_data)
    );

    // The accumulator is the write data of every command
    assign ram_if.w_data = pe_if.result;

    assign wr_en   = ram_if.w_en;
    assign wr_addr = ram_if.w_addr;
    assign wr_data = ram_if.w_data;

endmodule

// File: coproc_assertions.sv
/*
 * Concurrent checks on the coprocessor top level
 * Single-cycle writes, sticky done, no write after done, pc that never wraps
 */
`timescale 1ns/1ps

module coproc_assertions import coproc_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic            done,
    input logic [PC_W-1:0] pc,
    input logic            wr_en
);

    // Each command writes once, in its single WRITE cycle
    wr_single: assert property (@(posedge clk) disable iff (reset) wr_en |=> !wr_en)
        else $error("wr_en stayed high for two cycles");

    done_sticky: assert property (@(posedge clk) disable iff (reset) done |=> done)
        else $error("done fell while reset was low");

    no_write_after_done: assert property (@(posedge clk) disable iff (reset) done |-> !wr_en)
        else $error("a write happened after done");

    // The pc only counts up, apart from the jump back to the loop start,
    // so running off the end of the ROM shows up as a wrap to a lower address
    pc_no_wrap: assert property (@(posedge clk) disable iff (reset)
        pc != $past(pc) |-> pc > $past(pc) || pc == LOOP_START)
        else $error("pc wrapped or jumped back to an address other than the loop start");

endmodule

bind coproc_top coproc_assertions i_coproc_assertions (
    .clk   (clk),
    .reset (reset),
    .done  (done),
    .pc    (pc),
    .wr_en (wr_en)
);

// File: coproc_tb.sv
/*
 * Testbench for the modular arithmetic coprocessor
 * Reference model built from program.hex and ram_init.hex
 * Write checks against the expected queue, watchdog and closing report
 */
`timescale 1ns/1ps

module coproc_tb import coproc_pkg::*; ();

    logic                  clk;
    logic                  reset;
    logic                  done;
    logic [PC_W-1:0]       pc;
    logic                  wr_en;
    logic [RAM_ADDR_W-1:0] wr_addr;
    word_t                 wr_data;

    cmd_t        prog [ROM_DEPTH] = '{default: '0};
    word_t       ram_model [RAM_DEPTH] = '{default: '0};
    logic [21:0] expected [$];
    logic [21:0] exp_write;
    int          errors = 0;
    int          watchdog_cycles = 0;
    logic        done_seen = 1'b0;

    coproc_top i_coproc_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Runs the program the way the sequencer does and queues each write as {dest, value}
    task automatic build_expected();
        logic [63:0]     acc;
        logic [63:0]     opnd;
        logic [PC_W-1:0] p;
        int              loops;
        int              max_times;
        p         = '0;
        loops     = LOOP_COUNT;
        max_times = 0;
        foreach (prog[i])
            if (int'(prog[i].times) > max_times)
                max_times = prog[i].times;
        while (prog[p].times != 0 && expected.size() < ROM_DEPTH * LOOP_COUNT)
        begin
            acc  = 64'(ram_model[prog[p].src1]) % MODULUS;
            opnd = 64'(ram_model[prog[p].src2]) % MODULUS;
            repeat (prog[p].times)
            begin
                case (prog[p].op)
                    OP_ADD:   acc = (acc + opnd) % MODULUS;
                    OP_SUB:   acc = (acc + MODULUS - opnd) % MODULUS;
                    OP_CUBIC: acc = acc * acc % MODULUS * acc % MODULUS;
                    default:  acc = acc * opnd % MODULUS;
                endcase
            end
            ram_model[prog[p].dest] = acc[15:0];
            expected.push_back({prog[p].dest, acc[15:0]});
            // The loop body runs LOOP_COUNT times in total
            if (p == LOOP_END && loops > 1)
            begin
                p = LOOP_START;
                loops--;
            end
            else
                p++;
        end
        watchdog_cycles = ROM_DEPTH * LOOP_COUNT * (max_times + 4) + 100;
    endtask

    task automatic note_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_and_finish(input int failures);
        $display("Write checks finished with %0d errors", failures);
        if (failures == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    initial
    begin
        reset = 1'b1;
        $readmemh("program.hex", prog);
        $readmemh("ram_init.hex", ram_model);
        build_expected();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait (done);
        // Idle cycles after the halt, where any further write is caught
        repeat (20) @(posedge clk);
        report_and_finish(errors);
    end

    initial
    begin
        #1;
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout, done never came within %0d cycles", watchdog_cycles);
        report_and_finish(errors + 1);
    end

    // Outputs are compared on the falling edge, half a cycle after they settle
    always @(negedge clk)
    begin
        if (!reset && wr_en)
        begin
            assert (expected.size() > 0)
            else note_error($sformatf("write to %0d with no write left to expect", wr_addr));
            if (expected.size() > 0)
            begin
                exp_write = expected.pop_front();
                assert ({wr_addr, wr_data} == exp_write)
                else note_error($sformatf("write %0d = %h, expected %0d = %h",
                                          wr_addr, wr_data, exp_write[21:16], exp_write[15:0]));
            end
        end
        if (!reset && done && !done_seen)
        begin
            done_seen = 1'b1;
            assert (expected.size() == 0)
            else note_error($sformatf("done with %0d writes still expected", expected.size()));
        end
    end

endmodule

// File: program.hex
// One command per line: dest[28:23] src1[22:17] op[16:15] times[14:6] src2[5:0]
// op 0 ADD, 1 SUB, 2 CUBIC, 3 MULT; times 0 halts
0802004A
08848043
09138144
09990080
0A2800C8
0AA98085
0B2A8106
0A2D0080
0B960085
0C2F80C9
0C9C8045
0D0D0040
0D9E020F
0E0F824D
0EB48098
0F070080
0FBD8041
00000000

// File: ram_init.hex
// Operand RAM words 0 to 15, one 16-bit hex value per line
0001
FFEF
0005
1234
0003
FFF0
8000
00FF
0002
ABCD
0007
FFF5
4321
0010
0000
0100

// File: sim.f
coproc_pkg.sv
coproc_ifs.sv
program_rom.sv
operand_ram.sv
microcode_fsm.sv
modular_pe.sv
coproc_top.sv
coproc_assertions.sv
coproc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the coprocessor testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module coproc_tb -o coproc_sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/coproc_sim > sim.log 2>&1
status=$?
cat sim.log
[ "$status" -eq 0 ] && ! grep -q "Regression failed" sim.log || exit 1
